// File: hdl/render_pkg.sv
`default_nettype none

package render_pkg;

    // ------------------------------
    // Screen and number formats
    // ------------------------------
    localparam int screen_width  = 32;
    localparam int screen_height = 24;
    localparam int coord_bits    = 16;
    localparam int depth_bits    = 16;

    localparam logic [depth_bits-1:0] far_depth = '1; // Farthest possible depth.

    typedef logic [11:0] color12_t; // RGB444.
    typedef logic [15:0] color16_t; // RGB565.

    // ------------------------------
    // Geometry
    // ------------------------------
    typedef struct packed {
        logic signed [coord_bits-1:0] x;
        logic signed [coord_bits-1:0] y;
        logic [depth_bits-1:0]        z;
    } vertex_t;

    typedef struct packed {
        vertex_t  v0;
        vertex_t  v1;
        vertex_t  v2;
        color16_t color; // Flat, applies to the whole triangle.
    } triangle_t;

    typedef struct packed {
        logic signed [coord_bits-1:0] dx;
        logic signed [coord_bits-1:0] dy;
    } screen_offset_t;

    // Frame phase of the top level.
    typedef enum logic [1:0] {
        fill,
        fill_wait,
        triangle
    } render_phase_t;

    // ------------------------------
    // Helpers
    // ------------------------------

    // RGB444 to RGB565, low bits filled from the top bits of each channel.
    function automatic color16_t expand_color(input color12_t c);
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
        r = c[11:8];
        g = c[7:4];
        b = c[3:0];
        return {r, r[3], g, g[3:2], b, b[3]};
    endfunction

endpackage

`default_nettype wire

// File: hdl/pixel_if.sv
`timescale 1ns/1ps
`default_nettype none

interface pixel_if
    import render_pkg::*;
();

    logic [coord_bits-1:0] pixel_x;
    logic [coord_bits-1:0] pixel_y;
    logic [depth_bits-1:0] depth;
    color16_t              color;
    logic                  compare_depth; // Ask the memory stage for a depth test.
    logic                  valid;
    logic                  ready;

    modport source (
        output pixel_x, pixel_y, depth, color, compare_depth, valid,
        input  ready
    );

    modport sink (
        input  pixel_x, pixel_y, depth, color, compare_depth, valid,
        output ready
    );

endinterface

`default_nettype wire

// File: hdl/pixel_scanner.sv
`timescale 1ns/1ps
`default_nettype none

module pixel_scanner
    import render_pkg::*;
(
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic                  load,
    input  wire logic [coord_bits-1:0] x_min,
    input  wire logic [coord_bits-1:0] x_max,
    input  wire logic [coord_bits-1:0] y_min,
    input  wire logic [coord_bits-1:0] y_max,
    input  wire logic                  step,
    output logic [coord_bits-1:0]      x,
    output logic [coord_bits-1:0]      y,
    output logic                       done
);

    logic [coord_bits-1:0] x_min_r;
    logic [coord_bits-1:0] x_max_r;
    logic [coord_bits-1:0] y_max_r;
    logic                  row_end;

    assign row_end = (x == x_max_r);
    assign done    = row_end && (y == y_max_r); // Last position of the rectangle.

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            x       <= '0;
            y       <= '0;
            x_min_r <= '0;
            x_max_r <= '0;
            y_max_r <= '0;
        end else if (load) begin
            x       <= x_min;
            y       <= y_min;
            x_min_r <= x_min;
            x_max_r <= x_max;
            y_max_r <= y_max;
        end else if (step) begin
            if (row_end) begin
                x <= x_min_r; // Back to the left edge.
                y <= y + 1'b1;
            end else begin
                x <= x + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/screen_filler.sv
`timescale 1ns/1ps
`default_nettype none

module screen_filler
    import render_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     rst,
    input  wire logic     start,
    input  wire color12_t fill_color,
    output logic          busy,
    pixel_if.source       pix
);

    logic     active;
    logic     step;
    logic     last;
    color16_t color_r;

    assign step = pix.valid && pix.ready;
    assign busy = start || active;

    pixel_scanner scanner_i (
        .clk  (clk),
        .rst  (rst),
        .load (start),
        .x_min('0),
        .x_max(coord_bits'(screen_width - 1)),
        .y_min('0),
        .y_max(coord_bits'(screen_height - 1)),
        .step (step),
        .x    (pix.pixel_x),
        .y    (pix.pixel_y),
        .done (last)
    );

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            active <= 1'b0;
        end else if (start) begin
            active <= 1'b1;
        end else if (step && last) begin
            active <= 1'b0; // Last pixel of the screen taken.
        end
    end

    // Color is frozen for the whole frame.
    always_ff @(posedge clk) begin
        if (start) begin
            color_r <= expand_color(fill_color);
        end
    end

    assign pix.valid         = active;
    assign pix.color         = color_r;
    assign pix.depth         = far_depth;
    assign pix.compare_depth = 1'b0; // Fill overwrites unconditionally.

endmodule

`default_nettype wire

// File: hdl/vertex_transformer.sv
`timescale 1ns/1ps
`default_nettype none

module vertex_transformer
    import render_pkg::*;
(
    input  wire logic           clk,
    input  wire logic           rst,
    input  wire screen_offset_t screen_offset,
    input  wire triangle_t      in_triangle,
    input  wire logic           in_valid,
    output logic                in_ready,
    output triangle_t           out_triangle,
    output logic                out_valid,
    input  wire logic           out_ready,
    output logic                busy
);

    function automatic logic signed [coord_bits-1:0] clamp_coord(
        input logic signed [coord_bits:0] v,
        input int                         limit
    );
        logic signed [coord_bits-1:0] r;
        if (v < 0) begin
            r = '0;
        end else if (v > limit - 1) begin
            r = coord_bits'(limit - 1);
        end else begin
            r = v[coord_bits-1:0];
        end
        return r;
    endfunction

    function automatic vertex_t transform_vertex(input vertex_t v, input screen_offset_t off);
        logic signed [coord_bits:0] sx;
        logic signed [coord_bits:0] sy;
        vertex_t                    r;
        sx  = v.x + off.dx; // One extra bit, no wrap.
        sy  = v.y + off.dy;
        r.x = clamp_coord(sx, screen_width);
        r.y = clamp_coord(sy, screen_height);
        r.z = v.z;
        return r;
    endfunction

    assign in_ready = !out_valid || out_ready;
    assign busy     = out_valid;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (in_valid && in_ready) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            out_triangle.v0    <= transform_vertex(in_triangle.v0, screen_offset);
            out_triangle.v1    <= transform_vertex(in_triangle.v1, screen_offset);
            out_triangle.v2    <= transform_vertex(in_triangle.v2, screen_offset);
            out_triangle.color <= in_triangle.color;
        end
    end

endmodule

`default_nettype wire

// File: hdl/triangle_rasterizer.sv
`timescale 1ns/1ps
`default_nettype none

module triangle_rasterizer
    import render_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      rst,
    input  wire triangle_t in_triangle,
    input  wire logic      in_valid,
    output logic           in_ready,
    output logic           busy,
    pixel_if.source        pix
);

    typedef enum logic [1:0] {
        idle,
        setup,
        scan
    } raster_state_t;

    localparam int coef_bits = coord_bits + 2;
    localparam int sum_bits  = 2 * coord_bits + 6;

    raster_state_t state;
    triangle_t     tri_r;
    vertex_t       verts [3];

    logic signed [coef_bits-1:0] a_next [3];
    logic signed [coef_bits-1:0] b_next [3];
    logic signed [sum_bits-1:0]  c_next [3];
    logic signed [coef_bits-1:0] a_r [3];
    logic signed [coef_bits-1:0] b_r [3];
    logic signed [sum_bits-1:0]  c_r [3];
    logic signed [sum_bits-1:0]  area;
    logic signed [sum_bits-1:0]  edge_val [3];

    logic [coord_bits-1:0] x_lo, x_hi, y_lo, y_hi;
    logic [coord_bits-1:0] scan_x, scan_y;
    logic                  scan_done;
    logic                  covered;
    logic                  load;
    logic                  step;

    // ------------------------------
    // Setup: edge equations and box
    // ------------------------------
    always_comb begin
        verts[0] = tri_r.v0;
        verts[1] = tri_r.v1;
        verts[2] = tri_r.v2;
        for (int i = 0; i < 3; i++) begin
            a_next[i] = verts[i].y - verts[(i + 1) % 3].y;
            b_next[i] = verts[(i + 1) % 3].x - verts[i].x;
            c_next[i] = -(a_next[i] * verts[i].x + b_next[i] * verts[i].y);
        end
        area = a_next[0] * verts[2].x + b_next[0] * verts[2].y + c_next[0]; // Doubled.
        x_lo = verts[0].x;
        x_hi = verts[0].x;
        y_lo = verts[0].y;
        y_hi = verts[0].y;
        for (int i = 1; i < 3; i++) begin
            if ($unsigned(verts[i].x) < x_lo) x_lo = verts[i].x;
            if ($unsigned(verts[i].x) > x_hi) x_hi = verts[i].x;
            if ($unsigned(verts[i].y) < y_lo) y_lo = verts[i].y;
            if ($unsigned(verts[i].y) > y_hi) y_hi = verts[i].y;
        end
    end

    // ------------------------------
    // Scan: coverage of one pixel
    // ------------------------------
    always_comb begin
        covered = 1'b1;
        for (int i = 0; i < 3; i++) begin
            edge_val[i] = a_r[i] * $signed({1'b0, scan_x})
                        + b_r[i] * $signed({1'b0, scan_y}) + c_r[i];
            if (edge_val[i][sum_bits-1]) begin
                covered = 1'b0; // Outside this edge.
            end
        end
    end

    assign in_ready = (state == idle);
    assign busy     = (state != idle);
    assign load     = (state == setup) && (area > 0); // Non-positive area is culled.
    assign step     = (state == scan) && (!covered || pix.ready);

    pixel_scanner scanner_i (
        .clk  (clk),
        .rst  (rst),
        .load (load),
        .x_min(x_lo),
        .x_max(x_hi),
        .y_min(y_lo),
        .y_max(y_hi),
        .step (step),
        .x    (scan_x),
        .y    (scan_y),
        .done (scan_done)
    );

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= idle;
        end else begin
            case (state)
                idle:    if (in_valid) state <= setup;
                setup:   state <= load ? scan : idle;
                scan:    if (step && scan_done) state <= idle;
                default: state <= idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            tri_r <= in_triangle;
        end
        if (state == setup) begin
            a_r <= a_next;
            b_r <= b_next;
            c_r <= c_next;
        end
    end

    assign pix.valid         = (state == scan) && covered;
    assign pix.pixel_x       = scan_x;
    assign pix.pixel_y       = scan_y;
    assign pix.depth         = tri_r.v0.z;
    assign pix.color         = tri_r.color;
    assign pix.compare_depth = 1'b1;

endmodule

`default_nettype wire

// File: hdl/render_manager.sv
`timescale 1ns/1ps
`default_nettype none

module render_manager
    import render_pkg::*;
(
    input  wire logic           clk,
    input  wire logic           rst,
    input  wire logic           begin_frame,
    input  wire screen_offset_t screen_offset,
    input  wire triangle_t      triangle,
    input  wire logic           triangle_valid,
    output logic                triangle_ready,
    input  wire color12_t       fill_color,
    input  wire logic           fill_valid,
    output logic                fill_ready,
    output logic [coord_bits-1:0] out_pixel_x,
    output logic [coord_bits-1:0] out_pixel_y,
    output logic [depth_bits-1:0] out_depth,
    output color16_t            out_color,
    output logic                out_compare_depth,
    output logic                out_valid,
    input  wire logic           out_ready,
    output logic                busy
);

    render_phase_t phase;
    color12_t      fill_color_r;
    logic          in_tri;
    logic          filler_busy;
    logic          xf_in_ready, xf_out_valid, xf_busy;
    logic          rast_in_ready, rast_busy;
    triangle_t     xf_triangle;

    pixel_if fill_pix ();
    pixel_if tri_pix ();

    // ------------------------------
    // Frame phase FSM
    // ------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            phase <= fill;
        end else begin
            case (phase)
                fill:      phase <= fill_wait; // Start pulse goes out here.
                fill_wait: if (!filler_busy) phase <= render_pkg::triangle;
                render_pkg::triangle: if (begin_frame) phase <= fill;
                default:   phase <= fill;
            endcase
        end
    end

    assign in_tri = (phase == render_pkg::triangle);

    assign fill_ready = 1'b1;
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            fill_color_r <= '0;
        end else if (fill_valid) begin
            fill_color_r <= fill_color;
        end
    end

    screen_filler filler_i (
        .clk       (clk),
        .rst       (rst),
        .start     (phase == fill),
        .fill_color(fill_color_r),
        .busy      (filler_busy),
        .pix       (fill_pix.source)
    );

    vertex_transformer xf_i (
        .clk          (clk),
        .rst          (rst),
        .screen_offset(screen_offset),
        .in_triangle  (triangle),
        .in_valid     (triangle_valid && in_tri),
        .in_ready     (xf_in_ready),
        .out_triangle (xf_triangle),
        .out_valid    (xf_out_valid),
        .out_ready    (rast_in_ready && in_tri),
        .busy         (xf_busy)
    );

    triangle_rasterizer rast_i (
        .clk        (clk),
        .rst        (rst),
        .in_triangle(xf_triangle),
        .in_valid   (xf_out_valid && in_tri),
        .in_ready   (rast_in_ready),
        .busy       (rast_busy),
        .pix        (tri_pix.source)
    );

    assign triangle_ready = in_tri && xf_in_ready;
    assign busy           = in_tri ? (rast_busy || xf_busy) : filler_busy;

    // Only the selected stream sees the downstream ready.
    assign fill_pix.ready = !in_tri && out_ready;
    assign tri_pix.ready  = in_tri && out_ready;

    assign out_pixel_x       = in_tri ? tri_pix.pixel_x : fill_pix.pixel_x;
    assign out_pixel_y       = in_tri ? tri_pix.pixel_y : fill_pix.pixel_y;
    assign out_depth         = in_tri ? tri_pix.depth : fill_pix.depth;
    assign out_color         = in_tri ? tri_pix.color : fill_pix.color;
    assign out_compare_depth = in_tri ? tri_pix.compare_depth : fill_pix.compare_depth;
    assign out_valid         = in_tri ? tri_pix.valid : fill_pix.valid;

endmodule

`default_nettype wire

// File: dv/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    always #4 clk = ~clk; // 8 ns period.

endmodule

`default_nettype wire

// File: dv/render_manager_tb.sv
`timescale 1ns/1ps
`default_nettype none

module render_manager_tb
    import render_pkg::*;
();

    typedef struct packed {
        logic [coord_bits-1:0] x;
        logic [coord_bits-1:0] y;
        logic [depth_bits-1:0] depth;
        color16_t              color;
        logic                  compare;
    } pixel_t;

    logic                  clk;
    logic                  rst;
    logic                  begin_frame;
    screen_offset_t        screen_offset;
    triangle_t             tri_in;
    logic                  tri_valid;
    logic                  tri_ready;
    color12_t              fill_color;
    logic                  fill_valid;
    logic                  fill_ready;
    logic [coord_bits-1:0] out_pixel_x;
    logic [coord_bits-1:0] out_pixel_y;
    logic [depth_bits-1:0] out_depth;
    color16_t              out_color;
    logic                  out_compare_depth;
    logic                  out_valid;
    logic                  out_ready;
    logic                  busy;

    pixel_t expected [$];
    pixel_t got [$];

    tb_clock clock_i (.clk(clk));

    render_manager render_manager_i (
        .clk              (clk),
        .rst              (rst),
        .begin_frame      (begin_frame),
        .screen_offset    (screen_offset),
        .triangle         (tri_in),
        .triangle_valid   (tri_valid),
        .triangle_ready   (tri_ready),
        .fill_color       (fill_color),
        .fill_valid       (fill_valid),
        .fill_ready       (fill_ready),
        .out_pixel_x      (out_pixel_x),
        .out_pixel_y      (out_pixel_y),
        .out_depth        (out_depth),
        .out_color        (out_color),
        .out_compare_depth(out_compare_depth),
        .out_valid        (out_valid),
        .out_ready        (out_ready),
        .busy             (busy)
    );

    // ------------------------------
    // Failure handling
    // ------------------------------
    task automatic abort_run();
        $display("RESULT: FAIL");
        $fatal(1, "Simulation stopped after a failure.");
    endtask

    task automatic value_error(input string msg);
        $display("ERROR at %0t ns: %s", $time, msg);
        abort_run();
    endtask

    task automatic wait_timeout(input string what);
        $display("Timed out at %0t ns while waiting for %s.", $time, what);
        abort_run();
    endtask

    // ------------------------------
    // Reference model
    // ------------------------------
    function automatic color16_t widen_color(input color12_t c);
        int r;
        int g;
        int b;
        r = c[11:8];
        g = c[7:4];
        b = c[3:0];
        return color16_t'(((r * 2 + r / 8) << 11) | ((g * 4 + g / 4) << 5) | (b * 2 + b / 8));
    endfunction

    function automatic int clamp_model(input int v, input int limit);
        if (v < 0) begin
            return 0;
        end
        return (v >= limit) ? limit - 1 : v;
    endfunction

    function automatic int edge_fn(input int ax, ay, bx, by, px, py);
        return (bx - ax) * (py - ay) - (by - ay) * (px - ax);
    endfunction

    function automatic triangle_t make_triangle(input int x0, y0, x1, y1, x2, y2,
                                                input logic [15:0] z, input color16_t c);
        triangle_t t;
        t.v0.x  = coord_bits'(x0);
        t.v0.y  = coord_bits'(y0);
        t.v0.z  = z;
        t.v1.x  = coord_bits'(x1);
        t.v1.y  = coord_bits'(y1);
        t.v1.z  = z + 16'd1; // Other depths must be ignored.
        t.v2.x  = coord_bits'(x2);
        t.v2.y  = coord_bits'(y2);
        t.v2.z  = z + 16'd2;
        t.color = c;
        return t;
    endfunction

    task automatic expect_fill(input color12_t c);
        pixel_t p;
        for (int y = 0; y < screen_height; y++) begin
            for (int x = 0; x < screen_width; x++) begin
                p.x       = coord_bits'(x);
                p.y       = coord_bits'(y);
                p.depth   = far_depth;
                p.color   = widen_color(c);
                p.compare = 1'b0;
                expected.push_back(p);
            end
        end
    endtask

    task automatic expect_triangle(input triangle_t t, input screen_offset_t off);
        int     vx [3];
        int     vy [3];
        int     x_lo, x_hi, y_lo, y_hi;
        pixel_t p;
        vx[0] = clamp_model(int'(t.v0.x) + int'(off.dx), screen_width);
        vy[0] = clamp_model(int'(t.v0.y) + int'(off.dy), screen_height);
        vx[1] = clamp_model(int'(t.v1.x) + int'(off.dx), screen_width);
        vy[1] = clamp_model(int'(t.v1.y) + int'(off.dy), screen_height);
        vx[2] = clamp_model(int'(t.v2.x) + int'(off.dx), screen_width);
        vy[2] = clamp_model(int'(t.v2.y) + int'(off.dy), screen_height);
        if (edge_fn(vx[0], vy[0], vx[1], vy[1], vx[2], vy[2]) <= 0) begin
            return; // Culled.
        end
        x_lo = vx[0];
        x_hi = vx[0];
        y_lo = vy[0];
        y_hi = vy[0];
        for (int i = 1; i < 3; i++) begin
            x_lo = (vx[i] < x_lo) ? vx[i] : x_lo;
            x_hi = (vx[i] > x_hi) ? vx[i] : x_hi;
            y_lo = (vy[i] < y_lo) ? vy[i] : y_lo;
            y_hi = (vy[i] > y_hi) ? vy[i] : y_hi;
        end
        for (int y = y_lo; y <= y_hi; y++) begin
            for (int x = x_lo; x <= x_hi; x++) begin
                if (edge_fn(vx[0], vy[0], vx[1], vy[1], x, y) >= 0 &&
                    edge_fn(vx[1], vy[1], vx[2], vy[2], x, y) >= 0 &&
                    edge_fn(vx[2], vy[2], vx[0], vy[0], x, y) >= 0) begin
                    p.x       = coord_bits'(x);
                    p.y       = coord_bits'(y);
                    p.depth   = t.v0.z;
                    p.color   = t.color;
                    p.compare = 1'b1;
                    expected.push_back(p);
                end
            end
        end
    endtask

    // ------------------------------
    // Stimulus and collection
    // ------------------------------
    // All tasks start and end 1 ns after a rising edge.
    task automatic load_fill_color(input color12_t c);
        fill_color = c;
        fill_valid = 1'b1;
        @(negedge clk);
        assert (fill_ready) else value_error("fill_ready low");
        @(posedge clk);
        #1;
        fill_valid = 1'b0;
    endtask

    task automatic start_frame();
        int waited;
        waited = 0;
        while (!tri_ready) begin
            @(posedge clk);
            #1;
            waited++;
            if (waited > 1000) wait_timeout("the triangle phase before a new frame");
        end
        assert (!busy) else value_error("busy high before begin_frame");
        begin_frame = 1'b1;
        @(posedge clk);
        #1;
        begin_frame = 1'b0;
    endtask

    task automatic send_triangle(input triangle_t t, input screen_offset_t off);
        int waited;
        waited        = 0;
        out_ready     = 1'b0;
        tri_in        = t;
        screen_offset = off;
        tri_valid     = 1'b1;
        @(negedge clk);
        while (!tri_ready) begin
            waited++;
            if (waited > 1000) wait_timeout("triangle_ready");
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        tri_valid = 1'b0;
    endtask

    // Gathers pixels until the DUT is idle; span counts cycles from first to last pixel.
    task automatic collect_pixels(input bit random_ready, input bit in_fill, output int span);
        int     cycles;
        int     first;
        int     last;
        bit     finished;
        pixel_t p;
        got.delete();
        cycles    = 0;
        first     = -1;
        last      = 0;
        finished  = 1'b0;
        out_ready = random_ready ? 1'($urandom_range(1, 0)) : 1'b1;
        while (!finished) begin
            @(negedge clk);
            if (in_fill) begin
                assert (!tri_ready) else value_error("triangle_ready high during fill");
            end
            if (out_valid && out_ready) begin
                p = {out_pixel_x, out_pixel_y, out_depth, out_color, out_compare_depth};
                got.push_back(p);
                first = (first < 0) ? cycles : first;
                last  = cycles;
            end
            finished = !busy && !out_valid;
            cycles++;
            if (cycles > 20000) wait_timeout("the end of the pixel stream");
            @(posedge clk);
            #1;
            out_ready = random_ready ? 1'($urandom_range(1, 0)) : 1'b1;
        end
        span = (first < 0) ? 0 : last - first + 1;
    endtask

    task automatic compare_pixels(input string label);
        assert (got.size() == expected.size())
        else value_error($sformatf("%s: got %0d pixels, expected %0d",
                                   label, got.size(), expected.size()));
        foreach (expected[i]) begin
            assert (got[i] == expected[i])
            else value_error($sformatf(
                "%s: pixel %0d is (%0d,%0d) z=%h c=%h cmp=%b, expected (%0d,%0d) z=%h c=%h cmp=%b",
                label, i, got[i].x, got[i].y, got[i].depth, got[i].color, got[i].compare,
                expected[i].x, expected[i].y, expected[i].depth, expected[i].color,
                expected[i].compare));
        end
    endtask

    task automatic log_test(input string name);
        render_phase_t phase_seen;
        phase_seen = render_manager_i.phase;
        $display("[%0t] %s, phase %s", $time, name, phase_seen.name());
    endtask

    // ------------------------------
    // Tests
    // ------------------------------
    task automatic test_fill_after_reset();
        int span;
        log_test("fill after reset");
        expected.delete();
        expect_fill(12'h000);
        collect_pixels(1'b0, 1'b1, span);
        compare_pixels("reset fill");
        assert (span == screen_width * screen_height)
        else value_error($sformatf("fill took %0d cycles, expected 768", span));
    endtask

    task automatic test_new_fill_color();
        int span;
        log_test("new fill color");
        load_fill_color(12'h9C5);
        start_frame();
        expected.delete();
        expect_fill(12'h9C5);
        collect_pixels(1'b0, 1'b1, span);
        compare_pixels("colored fill");
    endtask

    task automatic test_front_triangle();
        triangle_t      t;
        screen_offset_t off;
        int             span;
        log_test("front-facing triangle");
        t      = make_triangle(2, 1, 14, 3, 5, 12, 16'h1234, 16'hA5C3);
        off.dx = 3;
        off.dy = 2;
        expected.delete();
        expect_triangle(t, off);
        send_triangle(t, off);
        collect_pixels(1'b0, 1'b0, span);
        assert (got.size() > 0) else value_error("front-facing triangle gave no pixels");
        compare_pixels("front triangle");
    endtask

    task automatic test_back_triangle();
        triangle_t      t;
        screen_offset_t off;
        int             span;
        log_test("back-facing triangle");
        t      = make_triangle(2, 1, 5, 12, 14, 3, 16'h0042, 16'h07E0);
        off.dx = 1;
        off.dy = 1;
        send_triangle(t, off);
        collect_pixels(1'b0, 1'b0, span);
        assert (got.size() == 0)
        else value_error($sformatf("back-facing triangle gave %0d pixels", got.size()));
    endtask

    task automatic test_back_pressure();
        triangle_t      ta;
        triangle_t      tb;
        screen_offset_t off_a;
        screen_offset_t off_b;
        int             span;
        log_test("back-pressure");
        load_fill_color(12'h3A7);
        start_frame();
        expected.delete();
        expect_fill(12'h3A7);
        collect_pixels(1'b1, 1'b1, span);
        compare_pixels("fill under back-pressure");
        ta       = make_triangle(0, 0, 9, 2, 3, 8, 16'h0100, 16'hF81F);
        tb       = make_triangle(20, 10, 30, 14, 22, 22, 16'h0200, 16'h001F);
        off_a.dx = 1;
        off_a.dy = 1;
        off_b.dx = -2;
        off_b.dy = 0;
        expected.delete();
        expect_triangle(ta, off_a);
        expect_triangle(tb, off_b);
        send_triangle(ta, off_a); // Second one follows on the next cycle.
        assert (tri_ready)
        else value_error("triangle_ready low while the first triangle moves on");
        send_triangle(tb, off_b);
        collect_pixels(1'b1, 1'b0, span);
        compare_pixels("triangles under back-pressure");
    endtask

    task automatic test_clamping();
        triangle_t      t [2];
        screen_offset_t off [2];
        int             span;
        log_test("clamping");
        t[0]      = make_triangle(25, 5, 40, 10, 22, 30, 16'h0777, 16'h8410);
        off[0].dx = 4;
        off[0].dy = -3;
        t[1]      = make_triangle(-5, -4, 10, -2, 2, 9, 16'h0888, 16'h4208);
        off[1].dx = -2;
        off[1].dy = -1;
        for (int i = 0; i < 2; i++) begin
            expected.delete();
            expect_triangle(t[i], off[i]);
            send_triangle(t[i], off[i]);
            collect_pixels(1'b0, 1'b0, span);
            foreach (got[j]) begin
                assert (got[j].x < screen_width && got[j].y < screen_height)
                else value_error($sformatf("pixel (%0d,%0d) off screen", got[j].x, got[j].y));
            end
            compare_pixels($sformatf("clamped triangle %0d", i));
        end
    endtask

    initial begin
        void'($urandom(32'h2bb4d7cc));
        rst           = 1'b1;
        begin_frame   = 1'b0;
        screen_offset = '0;
        tri_in        = '0;
        tri_valid     = 1'b0;
        fill_color    = '0;
        fill_valid    = 1'b0;
        out_ready     = 1'b0;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        test_fill_after_reset();
        test_new_fill_color();
        test_front_triangle();
        test_back_triangle();
        test_back_pressure();
        test_clamping();
        $display("RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
hdl/render_pkg.sv
hdl/pixel_if.sv
hdl/pixel_scanner.sv
hdl/screen_filler.sv
hdl/vertex_transformer.sv
hdl/triangle_rasterizer.sv
hdl/render_manager.sv
dv/tb_clock.sv
dv/render_manager_tb.sv
